// ==== verilog/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

  // instruction and address width
  localparam int xlen = 32;

  // fetch controller states
  typedef enum logic [1:0] {
    idle   = 2'd0,
    lookup = 2'd1,
    miss   = 2'd2,
    resp   = 2'd3
  } fetch_state_e;

  // apb slave phases
  typedef enum logic {
    setup  = 1'b0,
    access = 1'b1
  } apb_phase_e;

  // defaults for the top level parameters
  localparam int def_index_w     = 4;
  localparam int def_mem_aw      = 8;
  localparam int def_mem_latency = 3;

endpackage

`default_nettype wire

// ==== verilog/ifu_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_icache #(
  parameter int INDEX_W = ifu_pkg::def_index_w
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [ifu_pkg::xlen-1:0] lookup_addr_i,
  input  logic                     fill_en_i,
  input  logic [ifu_pkg::xlen-1:0] fill_data_i,
  input  logic                     flush_i,
  output logic                     hit_o,
  output logic [ifu_pkg::xlen-1:0] hit_data_o
);

  localparam int LINES = 1 << INDEX_W;
  localparam int TAG_W = ifu_pkg::xlen - INDEX_W - 2;

  logic [ifu_pkg::xlen-1:0] data_mem [LINES];
  logic [TAG_W-1:0]         tag_mem  [LINES];
  logic [LINES-1:0]         valid_q;

  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0]   tag;

  // byte offset bits are dropped
  assign index = lookup_addr_i[INDEX_W+1:2];
  assign tag   = lookup_addr_i[ifu_pkg::xlen-1:INDEX_W+2];

  assign hit_o      = valid_q[index] && (tag_mem[index] == tag);
  assign hit_data_o = data_mem[index];

  // flush overrides a fill in the same cycle
  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_en_i)
    begin
      valid_q[index] <= 1'b1;
    end
  end

  // line payload
  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      data_mem[index] <= fill_data_i;
      tag_mem[index]  <= tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ifu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch #(
  parameter int INDEX_W = ifu_pkg::def_index_w
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pc_valid_i,
  input  logic [ifu_pkg::xlen-1:0] pc_i,
  input  logic                     inst_ready_i,
  input  logic                     hit_i,
  input  logic [ifu_pkg::xlen-1:0] hit_data_i,
  input  logic                     mem_rvalid_i,
  input  logic [ifu_pkg::xlen-1:0] mem_rdata_i,
  output logic                     fetch_ready_o,
  output logic                     inst_valid_o,
  output logic [ifu_pkg::xlen-1:0] inst_o,
  output logic [ifu_pkg::xlen-1:0] inst_pc_o,
  output logic [ifu_pkg::xlen-1:0] lookup_addr_o,
  output logic                     fill_en_o,
  output logic [ifu_pkg::xlen-1:0] fill_data_o,
  output logic                     mem_arvalid_o,
  output logic [ifu_pkg::xlen-1:0] mem_araddr_o
);

  localparam int TAG_W = ifu_pkg::xlen - INDEX_W - 2;

  ifu_pkg::fetch_state_e state_q;
  ifu_pkg::fetch_state_e state_d;

  logic [ifu_pkg::xlen-1:0] pc_q;
  logic [ifu_pkg::xlen-1:0] inst_q;
  logic [TAG_W-1:0]         pc_tag;
  logic [INDEX_W-1:0]       pc_index;
  logic                     accept;

  assign accept = pc_valid_i && (state_q == ifu_pkg::idle);

  // word aligned address built from the registered pc
  assign pc_tag   = pc_q[ifu_pkg::xlen-1:INDEX_W+2];
  assign pc_index = pc_q[INDEX_W+1:2];

  assign lookup_addr_o = {pc_tag, pc_index, 2'b00};
  assign mem_araddr_o  = {pc_tag, pc_index, 2'b00};

  // one read per miss issued from the lookup cycle
  assign mem_arvalid_o = (state_q == ifu_pkg::lookup) && !hit_i;

  // returned word goes into the cache as it is presented
  assign fill_en_o   = (state_q == ifu_pkg::miss) && mem_rvalid_i;
  assign fill_data_o = mem_rdata_i;

  assign fetch_ready_o = (state_q == ifu_pkg::idle);
  assign inst_valid_o  = (state_q == ifu_pkg::resp);
  assign inst_o        = inst_q;
  assign inst_pc_o     = pc_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::idle:
      begin
        if (accept)
        begin
          state_d = ifu_pkg::lookup;
        end
      end
      ifu_pkg::lookup:
      begin
        state_d = hit_i ? ifu_pkg::resp : ifu_pkg::miss;
      end
      ifu_pkg::miss:
      begin
        if (mem_rvalid_i)
        begin
          state_d = ifu_pkg::resp;
        end
      end
      ifu_pkg::resp:
      begin
        // hold until downstream takes it
        if (inst_ready_i)
        begin
          state_d = ifu_pkg::idle;
        end
      end
      default:
      begin
        state_d = ifu_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ifu_pkg::idle;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // pc and output register
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pc_q <= pc_i;
    end
    if ((state_q == ifu_pkg::lookup) && hit_i)
    begin
      inst_q <= hit_data_i;
    end
    else if (fill_en_o)
    begin
      inst_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ifu_imem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_imem #(
  parameter int MEM_AW      = ifu_pkg::def_mem_aw,
  parameter int MEM_LATENCY = ifu_pkg::def_mem_latency
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [ifu_pkg::xlen-1:0] paddr_i,
  input  logic [ifu_pkg::xlen-1:0] pwdata_i,
  output logic [ifu_pkg::xlen-1:0] prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  logic                     mem_arvalid_i,
  input  logic [ifu_pkg::xlen-1:0] mem_araddr_i,
  output logic                     mem_rvalid_o,
  output logic [ifu_pkg::xlen-1:0] mem_rdata_o
);

  localparam int WORDS = 1 << MEM_AW;

  logic [ifu_pkg::xlen-1:0] mem [WORDS];

  ifu_pkg::apb_phase_e phase_q;

  logic                     apb_access;
  logic                     apb_in_range;
  logic                     fetch_in_range;
  logic [ifu_pkg::xlen-1:0] fetch_word;
  logic [MEM_LATENCY-1:0]   rvalid_pipe;
  logic [ifu_pkg::xlen-1:0] rdata_pipe [MEM_LATENCY];

  // setup phase seen last cycle means this is the access phase
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase_q <= ifu_pkg::setup;
    end
    else
    begin
      phase_q <= (psel_i && !penable_i) ? ifu_pkg::access : ifu_pkg::setup;
    end
  end

  assign apb_access   = psel_i && penable_i && (phase_q == ifu_pkg::access);
  assign apb_in_range = (paddr_i[ifu_pkg::xlen-1:MEM_AW+2] == '0);

  // no wait states
  assign pready_o  = psel_i && penable_i;
  assign pslverr_o = apb_access && !apb_in_range;
  assign prdata_o  = (apb_access && !pwrite_i && apb_in_range) ?
                     mem[paddr_i[MEM_AW+1:2]] : '0;

  always_ff @(posedge clk)
  begin
    if (apb_access && pwrite_i && apb_in_range)
    begin
      mem[paddr_i[MEM_AW+1:2]] <= pwdata_i;
    end
  end

  // fetch word sampled at request time
  assign fetch_in_range = (mem_araddr_i[ifu_pkg::xlen-1:MEM_AW+2] == '0);
  assign fetch_word     = fetch_in_range ? mem[mem_araddr_i[MEM_AW+1:2]] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_pipe <= '0;
    end
    else
    begin
      rvalid_pipe[0] <= mem_arvalid_i;
      for (int i = 1; i < MEM_LATENCY; i++)
      begin
        rvalid_pipe[i] <= rvalid_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    rdata_pipe[0] <= fetch_word;
    for (int i = 1; i < MEM_LATENCY; i++)
    begin
      rdata_pipe[i] <= rdata_pipe[i-1];
    end
  end

  assign mem_rvalid_o = rvalid_pipe[MEM_LATENCY-1];
  assign mem_rdata_o  = rdata_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
  parameter int INDEX_W     = ifu_pkg::def_index_w,
  parameter int MEM_AW      = ifu_pkg::def_mem_aw,
  parameter int MEM_LATENCY = ifu_pkg::def_mem_latency
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pc_valid_i,
  input  logic [ifu_pkg::xlen-1:0] pc_i,
  input  logic                     inst_ready_i,
  input  logic                     flush_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [ifu_pkg::xlen-1:0] paddr_i,
  input  logic [ifu_pkg::xlen-1:0] pwdata_i,
  output logic                     fetch_ready_o,
  output logic                     inst_valid_o,
  output logic [ifu_pkg::xlen-1:0] inst_o,
  output logic [ifu_pkg::xlen-1:0] inst_pc_o,
  output logic [ifu_pkg::xlen-1:0] prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o
);

  // cache port
  logic [ifu_pkg::xlen-1:0] lookup_addr;
  logic                     fill_en;
  logic [ifu_pkg::xlen-1:0] fill_data;
  logic                     hit;
  logic [ifu_pkg::xlen-1:0] hit_data;

  // fetch read channel
  logic                     mem_arvalid;
  logic [ifu_pkg::xlen-1:0] mem_araddr;
  logic                     mem_rvalid;
  logic [ifu_pkg::xlen-1:0] mem_rdata;

  ifu_fetch #(
    .INDEX_W (INDEX_W)
  ) fetch0 (
    .clk           (clk),
    .rst           (rst),
    .pc_valid_i    (pc_valid_i),
    .pc_i          (pc_i),
    .inst_ready_i  (inst_ready_i),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .fetch_ready_o (fetch_ready_o),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .lookup_addr_o (lookup_addr),
    .fill_en_o     (fill_en),
    .fill_data_o   (fill_data),
    .mem_arvalid_o (mem_arvalid),
    .mem_araddr_o  (mem_araddr)
  );

  ifu_icache #(
    .INDEX_W (INDEX_W)
  ) icache0 (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .fill_en_i     (fill_en),
    .fill_data_i   (fill_data),
    .flush_i       (flush_i),
    .hit_o         (hit),
    .hit_data_o    (hit_data)
  );

  ifu_imem #(
    .MEM_AW      (MEM_AW),
    .MEM_LATENCY (MEM_LATENCY)
  ) imem0 (
    .clk           (clk),
    .rst           (rst),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .mem_arvalid_i (mem_arvalid),
    .mem_araddr_i  (mem_araddr),
    .mem_rvalid_o  (mem_rvalid),
    .mem_rdata_o   (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verif/ifu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_props (
  input logic                     clk,
  input logic                     rst,
  input ifu_pkg::fetch_state_e    state_i,
  input logic                     fetch_ready_i,
  input logic                     inst_valid_i,
  input logic                     inst_ready_i,
  input logic [ifu_pkg::xlen-1:0] inst_i,
  input logic [ifu_pkg::xlen-1:0] inst_pc_i,
  input logic                     arvalid_i,
  input logic                     rvalid_i
);

  logic pending_q;

  // read outstanding from arvalid until rvalid
  always_ff @(posedge clk)
  begin
    if (rst)
      pending_q <= 1'b0;
    else if (arvalid_i)
      pending_q <= 1'b1;
    else if (rvalid_i)
      pending_q <= 1'b0;
  end

  one_read_in_flight: assert property (@(posedge clk) disable iff (rst)
    arvalid_i |-> !pending_q)
    else $error("fetch read issued while another read is outstanding");

  // a returned word lands while the controller waits in miss
  read_returns_to_miss: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> pending_q && (state_i == ifu_pkg::miss))
    else $error("fetch read returned with no request waiting in miss");

  // stalled response holds its payload
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i && !inst_ready_i |=> inst_valid_i && $stable(inst_i) && $stable(inst_pc_i))
    else $error("instruction output changed while stalled");

  ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
    !(fetch_ready_i && inst_valid_i))
    else $error("fetch_ready_o and inst_valid_o high together");

endmodule

bind ifu_fetch ifu_props props0 (
  .clk           (clk),
  .rst           (rst),
  .state_i       (state_q),
  .fetch_ready_i (fetch_ready_o),
  .inst_valid_i  (inst_valid_o),
  .inst_ready_i  (inst_ready_i),
  .inst_i        (inst_o),
  .inst_pc_i     (inst_pc_o),
  .arvalid_i     (mem_arvalid_o),
  .rvalid_i      (mem_rvalid_i)
);

`default_nettype wire

// ==== verif/ifu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int LATENCY     = ifu_pkg::def_mem_latency;
  localparam int IDX_W       = ifu_pkg::def_index_w;
  localparam int MEM_AW      = ifu_pkg::def_mem_aw;
  localparam int PROG_WORDS  = 32;
  localparam int FETCHES     = 83;
  localparam int LOAD_CYCLES = 10 + 4 * PROG_WORDS + 40;

  logic        clk;
  logic        rst;
  logic        pc_valid_i;
  logic [31:0] pc_i;
  logic        inst_ready_i;
  logic        flush_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] paddr_i;
  logic [31:0] pwdata_i;
  logic        fetch_ready_o;
  logic        inst_valid_o;
  logic [31:0] inst_o;
  logic [31:0] inst_pc_o;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  // shadow memory and shadow cache
  logic [31:0]         sh_mem   [1 << MEM_AW];
  logic [31:0]         sh_data  [1 << IDX_W];
  logic [31-IDX_W-2:0] sh_tag   [1 << IDX_W];
  logic [(1<<IDX_W)-1:0] sh_valid;

  logic [31:0] exp_inst_q [$];
  logic [31:0] exp_pc_q   [$];
  int          issued;
  int          taken;

  ifu_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      abort();
    end
  endtask

  // expected word for a pc and whether the shadow line hits
  function automatic logic [31:0] ref_fetch(input logic [31:0] pc, output bit hit);
    hit = sh_valid[pc[IDX_W+1:2]] && (sh_tag[pc[IDX_W+1:2]] == pc[31:IDX_W+2]);
    ref_fetch = hit ? sh_data[pc[IDX_W+1:2]] : sh_mem[pc[MEM_AW+1:2]];
  endfunction

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, input bit err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(posedge clk);
    #2 penable_i = 1'b1;
    @(posedge clk);
    check("pready_o", pready_o, 1);
    check("pslverr_o", pslverr_o, err);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    if (!err)
      sh_mem[addr[MEM_AW+1:2]] = data;
  endtask

  task automatic apb_read(input logic [31:0] addr, input bit err);
    logic [31:0] exp_word;
    exp_word  = err ? 32'h0 : sh_mem[addr[MEM_AW+1:2]];
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(posedge clk);
    #2 penable_i = 1'b1;
    @(posedge clk);
    check("pready_o", pready_o, 1);
    check("pslverr_o", pslverr_o, err);
    check("prdata_o", prdata_o, exp_word);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic flush_cache();
    flush_i = 1'b1;
    @(posedge clk);
    #2 flush_i = 1'b0;
    sh_valid = '0;
  endtask

  // offer one pc and take its instruction after an optional stall
  task automatic fetch(input logic [31:0] pc, input bit hold);
    logic [31:0] exp_word;
    bit          exp_hit;
    int          cycles;
    int          stall;
    exp_word = ref_fetch(pc, exp_hit);
    exp_inst_q.push_back(exp_word);
    exp_pc_q.push_back(pc);
    issued++;
    if (!exp_hit)
    begin
      sh_valid[pc[IDX_W+1:2]] = 1'b1;
      sh_tag[pc[IDX_W+1:2]]   = pc[31:IDX_W+2];
      sh_data[pc[IDX_W+1:2]]  = exp_word;
    end
    stall      = hold ? $urandom_range(1, 4) : 0;
    pc_valid_i = 1'b1;
    pc_i       = pc;
    @(posedge clk);
    check("fetch_ready_o", fetch_ready_o, 1);
    #2 pc_valid_i = 1'b0;
    inst_ready_i = (stall == 0);
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!inst_valid_o);
    if (exp_hit)
      check("inst_valid_o delay", cycles, 2);
    if (stall > 0)
    begin
      repeat (stall - 1) @(posedge clk);
      #2 inst_ready_i = 1'b1;
      @(posedge clk);
    end
    #2 inst_ready_i = 1'b0;
  endtask

  // every taken instruction against the expected queue
  always @(posedge clk)
  begin
    if (!rst && inst_valid_o && inst_ready_i)
    begin
      if (exp_inst_q.size() == 0)
      begin
        $display("instruction taken with no fetch outstanding");
        abort();
      end
      else
      begin
        check("inst_o", inst_o, exp_inst_q.pop_front());
        check("inst_pc_o", inst_pc_o, exp_pc_q.pop_front());
        taken++;
      end
    end
  end

  initial
  begin
    #(CLK_PERIOD * (FETCHES * (LATENCY + 8) + LOAD_CYCLES));
    $display("timeout: the fetch tests did not finish in time");
    abort();
  end

  initial
  begin
    void'($urandom(84));
    rst = 1'b1;
    pc_valid_i = 1'b0;
    pc_i = '0;
    inst_ready_i = 1'b0;
    flush_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    sh_valid = '0;
    issued = 0;
    taken = 0;
    repeat (10) @(posedge clk);
    #2 rst = 1'b0;
    check("fetch_ready_o", fetch_ready_o, 1);
    check("inst_valid_o", inst_valid_o, 0);
    check("pslverr_o", pslverr_o, 0);

    // load and read back before the cold fetches
    for (int i = 0; i < PROG_WORDS; i++)
      apb_write(4 * i, $urandom, 0);
    for (int i = 0; i < PROG_WORDS; i++)
      apb_read(4 * i, 0);
    for (int i = 0; i < PROG_WORDS; i++)
      fetch(4 * i, 0);

    // refetch hits with low pc bits set on some
    for (int i = 0; i < 8; i++)
      fetch(32'h40 + 4 * i + (i % 4), 0);

    // words 5 and 21 share index 5
    for (int i = 0; i < 8; i++)
      fetch((i % 2) ? 32'h54 : 32'h14, 0);

    // stale line until fence
    apb_write(32'h54, $urandom, 0);
    fetch(32'h54, 0);
    flush_cache();
    fetch(32'h54, 0);
    fetch(32'h54, 0);

    for (int i = 0; i < 32; i++)
      fetch(4 * $urandom_range(0, PROG_WORDS - 1), 1);

    // beyond the 256 word memory
    apb_write(32'h400, 32'hdead_beef, 1);
    apb_read(32'h400, 1);

    if (taken == issued && exp_inst_q.size() == 0)
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
    else
    begin
      $display("instruction count mismatch, %0d issued and %0d taken", issued, taken);
      abort();
    end
  end

endmodule

`default_nettype wire

// ==== ifu_top.f ====
verilog/ifu_pkg.sv
verilog/ifu_icache.sv
verilog/ifu_fetch.sv
verilog/ifu_imem.sv
verilog/ifu_top.sv
verif/ifu_props.sv
verif/ifu_tb.sv
